/* dbg_print_cfg.svh */
`ifndef DBG_PRINT_CFG_SVH
`define DBG_PRINT_CFG_SVH

// Register and transmit word width
`define DBG_WORD_W 32

// Mode select bus
`define DBG_MODE_W 8

// Mode value that selects the print unit
`define DBG_CMD_PRINT 8'h54

// Printed pipeline registers, npc through ctrm
`define DBG_NUM_REGS 10

// Line end characters
`define DBG_CHAR_CR 8'h0d
`define DBG_CHAR_LF 8'h0a

// Follows every register name
`define DBG_CHAR_EQ 8'h3d

`endif

/* dbg_print_pkg.sv */
`include "dbg_print_cfg.svh"

package dbg_print_pkg;

    // Print order index, 0 = npc ... 9 = ctrm
    typedef logic [3:0] reg_idx_t;

    // Letter position inside a label
    typedef logic [2:0] char_idx_t;

    typedef struct packed {
        logic [`DBG_WORD_W-9:0] pad; // Always zero
        logic [7:0]             ch;
    } tx_char_t;

    // One transmit word, seen either as a character or as raw data
    typedef union packed {
        tx_char_t               as_char;
        logic [`DBG_WORD_W-1:0] as_data;
    } tx_word_u;

endpackage

/* label_rom.sv */
`timescale 1ns/1ps
`include "dbg_print_cfg.svh"

module label_rom (
    input  dbg_print_pkg::reg_idx_t  reg_idx,
    input  dbg_print_pkg::char_idx_t char_idx,
    output logic [7:0]               label_char,
    output logic                     label_last
);

    logic [31:0]              name; // First letter in the top byte
    dbg_print_pkg::char_idx_t len;
    logic [7:0]               letter;

    always_comb begin
        case (reg_idx)
            4'd0:    begin name = {"NPC", 8'h00}; len = 3'd3; end
            4'd1:    begin name = {"PC", 16'h0};  len = 3'd2; end
            4'd2:    begin name = {"IR", 16'h0};  len = 3'd2; end
            4'd3:    begin name = {"PCD", 8'h00}; len = 3'd3; end
            4'd4:    begin name = {"IRE", 8'h00}; len = 3'd3; end
            4'd5:    begin name = {"IMM", 8'h00}; len = 3'd3; end
            4'd6:    begin name = {"A", 24'h0};   len = 3'd1; end
            4'd7:    begin name = {"B", 24'h0};   len = 3'd1; end
            4'd8:    begin name = {"Y", 24'h0};   len = 3'd1; end
            4'd9:    begin name = "CTRM";         len = 3'd4; end
            default: begin name = 32'h0;          len = 3'd0; end
        endcase
    end

    always_comb begin
        case (char_idx)
            3'd0:    letter = name[31:24];
            3'd1:    letter = name[23:16];
            3'd2:    letter = name[15:8];
            default: letter = name[7:0];
        endcase
    end

    // Position right after the name gives the terminator
    assign label_last = (char_idx >= len);
    assign label_char = label_last ? `DBG_CHAR_EQ : letter;

endmodule

/* step_control.sv */
`timescale 1ns/1ps
`include "dbg_print_cfg.svh"

module step_control (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`DBG_MODE_W-1:0] sel_mode,
    input  logic                   print_done,
    output logic                   clk_cpu,
    output logic                   active,
    output logic                   print_start,
    output logic                   finish
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_PRE   = 3'd1;
    localparam logic [2:0] S_HIGH  = 3'd2;
    localparam logic [2:0] S_LOW   = 3'd3;
    localparam logic [2:0] S_PRINT = 3'd4;
    localparam logic [2:0] S_DONE  = 3'd5;

    logic [2:0] state;
    logic [2:0] state_nxt;
    logic       cmd_match;

    assign cmd_match = (sel_mode == `DBG_CMD_PRINT);

    // Any other mode value aborts from every state
    always_comb begin
        state_nxt = state;
        if (!cmd_match) begin
            state_nxt = S_IDLE;
        end else begin
            case (state)
                S_IDLE:  state_nxt = S_PRE;
                S_PRE:   state_nxt = S_HIGH;
                S_HIGH:  state_nxt = S_LOW;
                S_LOW:   state_nxt = S_PRINT;
                S_PRINT: if (print_done) state_nxt = S_DONE;
                S_DONE:  state_nxt = S_DONE; // Held until the command is withdrawn
                default: state_nxt = S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= S_IDLE;
            clk_cpu     <= 1'b0;
            active      <= 1'b0;
            print_start <= 1'b0;
            finish      <= 1'b0;
        end else begin
            state       <= state_nxt;
            clk_cpu     <= (state_nxt == S_HIGH); // Single step pulse
            active      <= (state_nxt != S_IDLE);
            print_start <= (state == S_LOW) && (state_nxt == S_PRINT);
            finish      <= (state_nxt == S_DONE);
        end
    end

endmodule

/* print_sequencer.sv */
`timescale 1ns/1ps
`include "dbg_print_cfg.svh"

module print_sequencer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     active,
    input  logic                     print_start,
    input  logic                     tx_ack,
    input  logic [`DBG_WORD_W-1:0]   npc,
    input  logic [`DBG_WORD_W-1:0]   pc,
    input  logic [`DBG_WORD_W-1:0]   ir,
    input  logic [`DBG_WORD_W-1:0]   pcd,
    input  logic [`DBG_WORD_W-1:0]   ire,
    input  logic [`DBG_WORD_W-1:0]   imm,
    input  logic [`DBG_WORD_W-1:0]   a,
    input  logic [`DBG_WORD_W-1:0]   b,
    input  logic [`DBG_WORD_W-1:0]   y,
    input  logic [`DBG_WORD_W-1:0]   ctrm,
    output dbg_print_pkg::reg_idx_t  reg_idx,
    output dbg_print_pkg::char_idx_t char_idx,
    output logic                     print_done,
    output logic                     tx_req,
    output logic                     tx_type,
    output logic [`DBG_WORD_W-1:0]   tx_data,
    input  logic [7:0]               label_char,
    input  logic                     label_last
);

    localparam logic [2:0] P_IDLE  = 3'd0;
    localparam logic [2:0] P_LABEL = 3'd1;
    localparam logic [2:0] P_DATA  = 3'd2;
    localparam logic [2:0] P_CR    = 3'd3;
    localparam logic [2:0] P_LF    = 3'd4;

    logic [2:0]             phase;
    logic [`DBG_WORD_W-1:0] reg_word;
    dbg_print_pkg::tx_word_u word;
    logic                   accept;

    assign accept = tx_req && tx_ack;

    always_comb begin
        case (reg_idx)
            4'd0:    reg_word = npc;
            4'd1:    reg_word = pc;
            4'd2:    reg_word = ir;
            4'd3:    reg_word = pcd;
            4'd4:    reg_word = ire;
            4'd5:    reg_word = imm;
            4'd6:    reg_word = a;
            4'd7:    reg_word = b;
            4'd8:    reg_word = y;
            4'd9:    reg_word = ctrm;
            default: reg_word = '0;
        endcase
    end

    // Word follows the registered phase, so it stays put while waiting for ack
    always_comb begin
        word    = '0;
        tx_type = 1'b0;
        case (phase)
            P_LABEL: word.as_char.ch = label_char;
            P_DATA: begin
                word.as_data = reg_word;
                tx_type      = 1'b1;
            end
            P_CR:    word.as_char.ch = `DBG_CHAR_CR;
            P_LF:    word.as_char.ch = `DBG_CHAR_LF;
            default: word = '0;
        endcase
    end

    assign tx_data = word;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase      <= P_IDLE;
            reg_idx    <= '0;
            char_idx   <= '0;
            tx_req     <= 1'b0;
            print_done <= 1'b0;
        end else if (!active) begin
            phase      <= P_IDLE;
            reg_idx    <= '0;
            char_idx   <= '0;
            tx_req     <= 1'b0;
            print_done <= 1'b0;
        end else begin
            print_done <= 1'b0;
            if (phase == P_IDLE) begin
                if (print_start) begin
                    phase    <= P_LABEL;
                    reg_idx  <= '0;
                    char_idx <= '0;
                    tx_req   <= 1'b1;
                end
            end else if (accept) begin
                tx_req <= 1'b0; // One idle cycle between words
                case (phase)
                    P_LABEL: begin
                        if (label_last) begin
                            phase    <= P_DATA;
                            char_idx <= '0;
                        end else begin
                            char_idx <= char_idx + 1'b1;
                        end
                    end
                    P_DATA: begin
                        if (reg_idx == `DBG_NUM_REGS - 1) begin
                            phase <= P_CR;
                        end else begin
                            phase   <= P_LABEL;
                            reg_idx <= reg_idx + 1'b1;
                        end
                    end
                    P_CR:    phase <= P_LF;
                    default: begin
                        phase      <= P_IDLE; // LF taken, stream complete
                        print_done <= 1'b1;
                    end
                endcase
            end else begin
                tx_req <= 1'b1;
            end
        end
    end

endmodule

/* dbg_print_top.sv */
`timescale 1ns/1ps
`include "dbg_print_cfg.svh"

module dbg_print_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`DBG_MODE_W-1:0] sel_mode,
    input  logic [`DBG_WORD_W-1:0] npc,
    input  logic [`DBG_WORD_W-1:0] pc,
    input  logic [`DBG_WORD_W-1:0] ir,
    input  logic [`DBG_WORD_W-1:0] pcd,
    input  logic [`DBG_WORD_W-1:0] ire,
    input  logic [`DBG_WORD_W-1:0] imm,
    input  logic [`DBG_WORD_W-1:0] a,
    input  logic [`DBG_WORD_W-1:0] b,
    input  logic [`DBG_WORD_W-1:0] y,
    input  logic [`DBG_WORD_W-1:0] ctrm,
    input  logic                   tx_ack,
    output logic                   clk_cpu,
    output logic                   tx_req,
    output logic                   tx_type,
    output logic [`DBG_WORD_W-1:0] tx_data,
    output logic                   finish
);

    logic                     active;
    logic                     print_start;
    logic                     print_done;
    dbg_print_pkg::reg_idx_t  reg_idx;
    dbg_print_pkg::char_idx_t char_idx;
    logic [7:0]               label_char;
    logic                     label_last;

    step_control step_control_inst (
        .clk         (clk),
        .rstn        (rstn),
        .sel_mode    (sel_mode),
        .print_done  (print_done),
        .clk_cpu     (clk_cpu),
        .active      (active),
        .print_start (print_start),
        .finish      (finish)
    );

    label_rom label_rom_inst (
        .reg_idx    (reg_idx),
        .char_idx   (char_idx),
        .label_char (label_char),
        .label_last (label_last)
    );

    print_sequencer print_sequencer_inst (
        .clk         (clk),
        .rstn        (rstn),
        .active      (active),
        .print_start (print_start),
        .tx_ack      (tx_ack),
        .npc         (npc),
        .pc          (pc),
        .ir          (ir),
        .pcd         (pcd),
        .ire         (ire),
        .imm         (imm),
        .a           (a),
        .b           (b),
        .y           (y),
        .ctrm        (ctrm),
        .reg_idx     (reg_idx),
        .char_idx    (char_idx),
        .print_done  (print_done),
        .tx_req      (tx_req),
        .tx_type     (tx_type),
        .tx_data     (tx_data),
        .label_char  (label_char),
        .label_last  (label_last)
    );

endmodule

/* dbg_print_assertions.sv */
`timescale 1ns/1ps
`include "dbg_print_cfg.svh"

module dbg_print_assertions (
    input logic                   clk,
    input logic                   rstn,
    input logic                   active,
    input logic                   tx_req,
    input logic                   tx_ack,
    input logic [`DBG_WORD_W-1:0] tx_data,
    input logic                   clk_cpu
);

    int fail_cnt = 0; // Failed assertion count

    // A waiting word stays offered and unchanged
    req_hold: assert property (@(posedge clk) disable iff (!rstn)
        tx_req && !tx_ack && active |=> tx_req && $stable(tx_data))
        else begin
            fail_cnt++;
            $error("tx_req dropped or tx_data changed before tx_ack");
        end

    req_gap: assert property (@(posedge clk) disable iff (!rstn)
        tx_req && tx_ack |=> !tx_req)
        else begin
            fail_cnt++;
            $error("tx_req still high the cycle after tx_ack");
        end

    // Single step only
    step_width: assert property (@(posedge clk) disable iff (!rstn)
        clk_cpu |=> !clk_cpu)
        else begin
            fail_cnt++;
            $error("clk_cpu high for two consecutive cycles");
        end

endmodule

bind print_sequencer dbg_print_assertions handshake_checks (
    .clk     (clk),
    .rstn    (rstn),
    .active  (active),
    .tx_req  (tx_req),
    .tx_ack  (tx_ack),
    .tx_data (tx_data),
    .clk_cpu (1'b0)
);

bind step_control dbg_print_assertions step_checks (
    .clk     (clk),
    .rstn    (rstn),
    .active  (1'b0),
    .tx_req  (1'b0),
    .tx_ack  (1'b0),
    .tx_data ('0),
    .clk_cpu (clk_cpu)
);

/* tb_dbg_print.sv */
`timescale 1ns/1ps
`include "dbg_print_cfg.svh"

module tb_dbg_print;

    localparam int          CLK_PERIOD     = 100;
    localparam int          NUM_SESSIONS   = 20;
    localparam int          SESSION_CYCLES = 700;
    localparam int          MAX_ACK_DELAY  = 4;
    localparam logic [31:0] SEED           = 32'h88c0_f70f;

    logic                   clk;
    logic                   rstn;
    logic [`DBG_MODE_W-1:0] sel_mode;
    logic [`DBG_WORD_W-1:0] cpu_reg [0:`DBG_NUM_REGS-1];
    logic                   tx_ack;
    logic                   clk_cpu;
    logic                   tx_req;
    logic                   tx_type;
    logic [`DBG_WORD_W-1:0] tx_data;
    logic                   finish;

    logic                   exp_type [$]; // Expected stream rebuilt at each step
    logic [`DBG_WORD_W-1:0] exp_word [$];
    int                     err_cnt = 0;
    int                     pulse_cnt = 0;
    int                     accepted_cnt = 0;
    logic                   held = 1'b0;
    logic [`DBG_WORD_W-1:0] held_word;

    dbg_print_top dbg_print_top_inst (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .npc      (cpu_reg[0]),
        .pc       (cpu_reg[1]),
        .ir       (cpu_reg[2]),
        .pcd      (cpu_reg[3]),
        .ire      (cpu_reg[4]),
        .imm      (cpu_reg[5]),
        .a        (cpu_reg[6]),
        .b        (cpu_reg[7]),
        .y        (cpu_reg[8]),
        .ctrm     (cpu_reg[9]),
        .tx_ack   (tx_ack),
        .clk_cpu  (clk_cpu),
        .tx_req   (tx_req),
        .tx_type  (tx_type),
        .tx_data  (tx_data),
        .finish   (finish)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    function automatic string reg_name(input int r);
        case (r)
            0:       return "NPC";
            1:       return "PC";
            2:       return "IR";
            3:       return "PCD";
            4:       return "IRE";
            5:       return "IMM";
            6:       return "A";
            7:       return "B";
            8:       return "Y";
            9:       return "CTRM";
            default: return "";
        endcase
    endfunction

    // Any mode value except the print command
    function automatic logic [`DBG_MODE_W-1:0] other_mode();
        logic [`DBG_MODE_W-1:0] m;
        m = $urandom;
        if (m == `DBG_CMD_PRINT) m = m ^ 8'h01;
        return m;
    endfunction

    task automatic push_char(input logic [7:0] ch);
        dbg_print_pkg::tx_word_u w;
        w            = '0;
        w.as_char.ch = ch;
        exp_type.push_back(1'b0);
        exp_word.push_back(w.as_data);
    endtask

    task automatic load_expected();
        string name;
        exp_type.delete();
        exp_word.delete();
        for (int r = 0; r < `DBG_NUM_REGS; r++) begin
            name = reg_name(r);
            for (int c = 0; c < name.len(); c++) begin
                push_char(name[c]);
            end
            push_char(`DBG_CHAR_EQ);
            exp_type.push_back(1'b1);
            exp_word.push_back(cpu_reg[r]);
        end
        push_char(`DBG_CHAR_CR);
        push_char(`DBG_CHAR_LF);
    endtask

    // CPU model loads one new register set per step
    always @(posedge clk_cpu) begin
        #5;
        for (int i = 0; i < `DBG_NUM_REGS; i++) begin
            cpu_reg[i] = $urandom;
        end
        load_expected();
    end

    // Transmitter model
    initial begin
        int   wait_cnt;
        logic cmd_prev;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            cmd_prev = (sel_mode == `DBG_CMD_PRINT); // No acks once the command is gone
            #5;
            if (tx_ack) begin
                tx_ack   = 1'b0;
                wait_cnt = $urandom % (MAX_ACK_DELAY + 1);
            end else if (tx_req && cmd_prev) begin
                if (wait_cnt == 0) tx_ack = 1'b1;
                else wait_cnt--;
            end
        end
    end

    // Stream checker samples mid-cycle
    always @(negedge clk) begin
        if (!rstn) begin
            held = 1'b0;
        end else begin
            if (clk_cpu) pulse_cnt++;
            if (held && tx_req && tx_data !== held_word)
                report_mismatch("back_pressure", held_word, tx_data);
            held      = tx_req && !tx_ack;
            held_word = tx_data;
            if (tx_req && tx_ack) begin
                accepted_cnt++;
                if (exp_word.size() == 0) begin
                    report_problem("word accepted while none was expected");
                end else begin
                    if (tx_type !== exp_type[0])
                        report_mismatch("stream_type", exp_type[0], tx_type);
                    if (tx_data !== exp_word[0])
                        report_mismatch("stream_word", exp_word[0], tx_data);
                    exp_type.delete(0);
                    exp_word.delete(0);
                end
            end
            if (finish && exp_word.size() != 0)
                report_problem("finish raised before the LF word was taken");
        end
    end

    task automatic run_session(input bit do_abort);
        int abort_at;
        int base_pulses;
        int hold;
        int gap;
        abort_at     = 1 + $urandom % 44; // Stream has 45 words
        hold         = 1 + $urandom % 8;
        gap          = 2 + $urandom % 5;
        base_pulses  = pulse_cnt;
        accepted_cnt = 0;
        @(posedge clk);
        #5 sel_mode = `DBG_CMD_PRINT;
        // Pulse on the second edge after the command appears
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            if (clk_cpu !== (i == 2)) report_mismatch("step_pulse", (i == 2), clk_cpu);
        end
        if (do_abort) begin
            while (accepted_cnt < abort_at) @(negedge clk);
        end else begin
            while (!finish) @(negedge clk);
            repeat (hold) begin
                @(negedge clk);
                if (finish !== 1'b1) report_mismatch("finish_hold", 1, finish);
            end
        end
        @(posedge clk);
        #5 sel_mode = other_mode();
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (tx_req !== 1'b0) report_mismatch("release_tx_req", 0, tx_req);
        if (finish !== 1'b0) report_mismatch("release_finish", 0, finish);
        repeat (gap) begin
            @(posedge clk);
            #5 sel_mode = other_mode();
        end
        @(negedge clk);
        if (pulse_cnt - base_pulses != 1)
            report_mismatch("step_count", 1, pulse_cnt - base_pulses);
    endtask

    initial begin
        int assert_cnt;
        void'($urandom(SEED));
        rstn     = 1'b0;
        sel_mode = other_mode();
        tx_ack   = 1'b0;
        for (int i = 0; i < `DBG_NUM_REGS; i++) begin
            cpu_reg[i] = '0;
        end
        repeat (10) @(posedge clk);
        #5 rstn = 1'b1;
        @(negedge clk);
        if (clk_cpu !== 1'b0) report_mismatch("reset_clk_cpu", 0, clk_cpu);
        if (tx_req !== 1'b0) report_mismatch("reset_tx_req", 0, tx_req);
        if (finish !== 1'b0) report_mismatch("reset_finish", 0, finish);
        for (int s = 0; s < NUM_SESSIONS; s++) begin
            run_session(s % 3 == 2); // Every third session aborts
        end
        assert_cnt = dbg_print_top_inst.print_sequencer_inst.handshake_checks.fail_cnt
                   + dbg_print_top_inst.step_control_inst.step_checks.fail_cnt;
        $display("Errors: %0d testbench, %0d assertion", err_cnt, assert_cnt);
        if (err_cnt == 0 && assert_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_SESSIONS * SESSION_CYCLES * CLK_PERIOD);
        $display("Timeout: the sessions did not complete in the expected time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* dbg_print.f */
+incdir+.
dbg_print_pkg.sv
label_rom.sv
step_control.sv
print_sequencer.sv
dbg_print_top.sv
dbg_print_assertions.sv
tb_dbg_print.sv
